// ==== rtl/smem_pkg.sv ====
package smem_pkg;

	// ------------------------------------------------------------------------
	// batch and store sizes
	// ------------------------------------------------------------------------
	localparam int MAX_READ       = 16;
	localparam int READ_NUM_W     = 4;
	localparam int BATCH_W        = 5;
	localparam int SLOTS_PER_READ = 20;
	localparam int SLOT_IDX_W     = 5;
	localparam int SLOT_ADDR_W    = 9;
	localparam int RET_W          = 7;
	localparam int LANE_W         = 256;
	localparam int BEAT_W         = 512;

	// compacted slot as kept in the store, 113 bits
	typedef struct packed {
		logic [6:0]  info_hi;
		logic [6:0]  info_lo;
		logic [32:0] x2;
		logic [32:0] x1;
		logic [32:0] x0;
	} slot_t;

	// slot as it travels on a 256-bit lane, padding is zero
	typedef struct packed {
		logic [24:0] pad_info_hi;
		logic [6:0]  info_hi;
		logic [24:0] pad_info_lo;
		logic [6:0]  info_lo;
		logic [30:0] pad_x2;
		logic [32:0] x2;
		logic [30:0] pad_x1;
		logic [32:0] x1;
		logic [30:0] pad_x0;
		logic [32:0] x0;
	} lane_t;

	// first beat of every read
	typedef struct packed {
		logic [351:0] zero_hi;
		logic [31:0]  ret;
		logic [56:0]  zero_mid;
		logic [6:0]   mem_size;
		logic [53:0]  zero_lo;
		logic [9:0]   read_num;
	} header_beat_t;

	// low half holds the first slot of the pair
	typedef struct packed {
		lane_t hi;
		lane_t lo;
	} pair_beat_t;

	typedef union packed {
		header_beat_t header;
		pair_beat_t   pair;
	} out_beat_u;

	typedef enum logic [1:0] {
		beat_none,
		beat_header,
		beat_pair,
		beat_single
	} beat_kind_t;

	typedef struct packed {
		beat_kind_t              kind;
		logic [READ_NUM_W-1:0]   read_num;
		logic [SLOT_IDX_W-1:0]   slot_idx;
		logic [SLOT_IDX_W-1:0]   mem_size;
	} beat_cmd_t;

	// mem size or ret report from the datapath
	typedef struct packed {
		logic                    valid;
		logic [READ_NUM_W-1:0]   read_num;
		logic [RET_W-1:0]        value;
	} rpt_t;

endpackage

// ==== rtl/batch_tracker.sv ====
`timescale 1ns/10ps

module batch_tracker (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic [smem_pkg::BATCH_W-1:0]  batch_size,
	input  logic                          size_valid,
	output logic                          output_request
);
	import smem_pkg::*;

	logic [BATCH_W-1:0] done_count;
	logic               batch_ready;

	// every read reports its mem size exactly once
	assign batch_ready = (done_count == batch_size) && (batch_size != '0);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			done_count <= '0;
		end else if (size_valid) begin
			done_count <= done_count + BATCH_W'(1);
		end
	end

	// request follows the compare one cycle later
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_request <= 1'b0;
		end else begin
			output_request <= batch_ready;
		end
	end

endmodule

// ==== rtl/output_sequencer.sv ====
`timescale 1ns/10ps

module output_sequencer (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic [smem_pkg::BATCH_W-1:0]      batch_size,
	input  logic                              output_permit,
	input  logic [smem_pkg::SLOT_IDX_W-1:0]   read_size,
	output smem_pkg::beat_cmd_t               cmd,
	output logic                              seq_done
);
	import smem_pkg::*;

	typedef enum logic [1:0] {
		st_header,
		st_pairs,
		st_gap,
		st_done
	} state_t;

	state_t                 state;
	logic [BATCH_W-1:0]     read_ptr;
	logic [SLOT_IDX_W-1:0]  slot_ptr;
	logic [SLOT_IDX_W-1:0]  cur_size;
	logic [SLOT_IDX_W-1:0]  remaining;
	logic                   all_issued;

	assign remaining  = cur_size - slot_ptr;
	assign all_issued = (read_ptr >= batch_size);
	assign seq_done   = (state == st_done);

	// ------------------------------------------------------------------------
	// beat command, one per cycle while permitted
	// ------------------------------------------------------------------------
	always_comb begin
		cmd          = '0;
		cmd.kind     = beat_none;
		cmd.read_num = read_ptr[READ_NUM_W-1:0];
		cmd.slot_idx = slot_ptr;
		cmd.mem_size = cur_size;
		if (output_permit) begin
			case (state)
				st_header: begin
					if (!all_issued) begin
						cmd.kind     = beat_header;
						cmd.mem_size = read_size;
					end
				end
				st_pairs: begin
					if (remaining >= SLOT_IDX_W'(2)) begin
						cmd.kind = beat_pair;
					end else if (remaining == SLOT_IDX_W'(1)) begin
						cmd.kind = beat_single;
					end
				end
				default: begin
					cmd.kind = beat_none;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// read and slot pointers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state    <= st_header;
			read_ptr <= '0;
			slot_ptr <= '0;
			cur_size <= '0;
		end else if (output_permit) begin
			case (state)
				st_header: begin
					if (all_issued) begin
						state <= st_done;
					end else begin
						cur_size <= read_size;
						slot_ptr <= '0;
						// empty read gets its header only
						state    <= (read_size == '0) ? st_gap : st_pairs;
					end
				end
				st_pairs: begin
					if (remaining >= SLOT_IDX_W'(2)) begin
						slot_ptr <= slot_ptr + SLOT_IDX_W'(2);
						if (remaining == SLOT_IDX_W'(2)) begin
							state <= st_gap;
						end
					end else begin
						slot_ptr <= slot_ptr + SLOT_IDX_W'(1);
						state    <= st_gap;
					end
				end
				st_gap: begin
					// table address moves here, ready for the next header
					read_ptr <= read_ptr + BATCH_W'(1);
					state    <= st_header;
				end
				default: begin
					state <= st_done;
				end
			endcase
		end
	end

endmodule

// ==== rtl/slot_store.sv ====
`timescale 1ns/10ps

module slot_store (
	input  logic                              clk,
	input  logic                              slot_we,
	input  logic [smem_pkg::READ_NUM_W-1:0]   slot_read_num,
	input  logic [smem_pkg::SLOT_IDX_W-1:0]   slot_idx,
	input  smem_pkg::lane_t                   slot_lane,
	input  logic [smem_pkg::READ_NUM_W-1:0]   rd_read_num,
	input  logic [smem_pkg::SLOT_IDX_W-1:0]   rd_idx,
	output smem_pkg::slot_t                   slot_a,
	output smem_pkg::slot_t                   slot_b
);
	import smem_pkg::*;

	localparam int DEPTH = MAX_READ * SLOTS_PER_READ;

	slot_t                   mem [DEPTH];
	logic [SLOT_ADDR_W-1:0]  wr_addr;
	logic [SLOT_ADDR_W-1:0]  rd_addr_a;
	logic [SLOT_ADDR_W-1:0]  rd_addr_b;
	slot_t                   wr_slot;

	// read number times slots per read, plus slot index
	function automatic logic [SLOT_ADDR_W-1:0] slot_addr(
		input logic [READ_NUM_W-1:0] read_num,
		input logic [SLOT_IDX_W-1:0] idx
	);
		return SLOT_ADDR_W'(read_num) * SLOT_ADDR_W'(SLOTS_PER_READ) + SLOT_ADDR_W'(idx);
	endfunction

	// drop the zero padding of the lane
	function automatic slot_t compact(input lane_t lane);
		slot_t s;
		s.info_hi = lane.info_hi;
		s.info_lo = lane.info_lo;
		s.x2      = lane.x2;
		s.x1      = lane.x1;
		s.x0      = lane.x0;
		return s;
	endfunction

	assign wr_addr   = slot_addr(slot_read_num, slot_idx);
	assign wr_slot   = compact(slot_lane);
	assign rd_addr_a = slot_addr(rd_read_num, rd_idx);
	// second slot of a pair
	assign rd_addr_b = rd_addr_a + SLOT_ADDR_W'(1);

	always_ff @(posedge clk) begin
		if (slot_we) begin
			mem[wr_addr] <= wr_slot;
		end
		slot_a <= mem[rd_addr_a];
		slot_b <= mem[rd_addr_b];
	end

endmodule

// ==== rtl/read_info_table.sv ====
`timescale 1ns/10ps

module read_info_table (
	input  logic                              clk,
	input  smem_pkg::rpt_t                    size_rpt,
	input  smem_pkg::rpt_t                    ret_rpt,
	input  logic [smem_pkg::READ_NUM_W-1:0]   rd_read_num,
	output logic [smem_pkg::SLOT_IDX_W-1:0]   read_size,
	output logic [smem_pkg::RET_W-1:0]        read_ret
);
	import smem_pkg::*;

	logic [SLOT_IDX_W-1:0] size_mem [MAX_READ];
	logic [RET_W-1:0]      ret_mem  [MAX_READ];

	always_ff @(posedge clk) begin
		if (size_rpt.valid) begin
			// at most 20 slots, so the low bits hold the size
			size_mem[size_rpt.read_num] <= size_rpt.value[SLOT_IDX_W-1:0];
		end
		if (ret_rpt.valid) begin
			ret_mem[ret_rpt.read_num] <= ret_rpt.value;
		end
	end

	// sequencer needs the size in the header cycle itself
	assign read_size = size_mem[rd_read_num];

	// ret lines up with the slot RAM read
	always_ff @(posedge clk) begin
		read_ret <= ret_mem[rd_read_num];
	end

endmodule

// ==== rtl/output_packer.sv ====
`timescale 1ns/10ps

module output_packer (
	input  logic                          clk,
	input  logic                          reset_n,
	input  smem_pkg::beat_cmd_t           cmd,
	input  logic                          seq_done,
	input  smem_pkg::slot_t               slot_a,
	input  smem_pkg::slot_t               slot_b,
	input  logic [smem_pkg::RET_W-1:0]    read_ret,
	output smem_pkg::out_beat_u           output_data,
	output logic                          output_valid,
	output logic                          output_finish
);
	import smem_pkg::*;

	beat_cmd_t  cmd_q;
	out_beat_u  next_word;
	logic       done_q;

	// put the slot fields back at their lane positions
	function automatic lane_t expand(input slot_t s);
		lane_t l;
		l         = '0;
		l.info_hi = s.info_hi;
		l.info_lo = s.info_lo;
		l.x2      = s.x2;
		l.x1      = s.x1;
		l.x0      = s.x0;
		return l;
	endfunction

	// ------------------------------------------------------------------------
	// word build, one stage behind the command
	// ------------------------------------------------------------------------
	always_comb begin
		next_word = '0;
		case (cmd_q.kind)
			beat_header: begin
				next_word.header.read_num = 10'(cmd_q.read_num);
				next_word.header.mem_size = 7'(cmd_q.mem_size);
				next_word.header.ret      = 32'(read_ret);
			end
			beat_pair: begin
				next_word.pair.lo = expand(slot_a);
				next_word.pair.hi = expand(slot_b);
			end
			beat_single: begin
				next_word.pair.lo = expand(slot_a);
			end
			default: begin
				next_word = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cmd_q         <= '0;
			output_valid  <= 1'b0;
			done_q        <= 1'b0;
			output_finish <= 1'b0;
		end else begin
			cmd_q         <= cmd;
			output_valid  <= (cmd_q.kind != beat_none);
			done_q        <= seq_done;
			output_finish <= done_q;
		end
	end

	always_ff @(posedge clk) begin
		output_data <= next_word;
	end

endmodule

// ==== rtl/smem_buffer_top.sv ====
`timescale 1ns/10ps

module smem_buffer_top (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic [smem_pkg::BATCH_W-1:0]      batch_size,

	input  logic                              slot_we,
	input  logic [smem_pkg::READ_NUM_W-1:0]   slot_read_num,
	input  logic [smem_pkg::SLOT_IDX_W-1:0]   slot_idx,
	input  smem_pkg::lane_t                   slot_lane,

	input  smem_pkg::rpt_t                    size_rpt,
	input  smem_pkg::rpt_t                    ret_rpt,

	output logic                              output_request,
	input  logic                              output_permit,
	output smem_pkg::out_beat_u               output_data,
	output logic                              output_valid,
	output logic                              output_finish
);
	import smem_pkg::*;

	beat_cmd_t              cmd;
	logic                   seq_done;
	logic [SLOT_IDX_W-1:0]  read_size;
	logic [RET_W-1:0]       read_ret;
	slot_t                  slot_a;
	slot_t                  slot_b;

	batch_tracker u_batch_tracker (
		.clk            (clk),
		.reset_n        (reset_n),
		.batch_size     (batch_size),
		.size_valid     (size_rpt.valid),
		.output_request (output_request)
	);

	output_sequencer u_output_sequencer (
		.clk           (clk),
		.reset_n       (reset_n),
		.batch_size    (batch_size),
		.output_permit (output_permit),
		.read_size     (read_size),
		.cmd           (cmd),
		.seq_done      (seq_done)
	);

	// store is written by the datapath and read by the beat command
	slot_store u_slot_store (
		.clk           (clk),
		.slot_we       (slot_we),
		.slot_read_num (slot_read_num),
		.slot_idx      (slot_idx),
		.slot_lane     (slot_lane),
		.rd_read_num   (cmd.read_num),
		.rd_idx        (cmd.slot_idx),
		.slot_a        (slot_a),
		.slot_b        (slot_b)
	);

	read_info_table u_read_info_table (
		.clk         (clk),
		.size_rpt    (size_rpt),
		.ret_rpt     (ret_rpt),
		.rd_read_num (cmd.read_num),
		.read_size   (read_size),
		.read_ret    (read_ret)
	);

	output_packer u_output_packer (
		.clk           (clk),
		.reset_n       (reset_n),
		.cmd           (cmd),
		.seq_done      (seq_done),
		.slot_a        (slot_a),
		.slot_b        (slot_b),
		.read_ret      (read_ret),
		.output_data   (output_data),
		.output_valid  (output_valid),
		.output_finish (output_finish)
	);

endmodule

// ==== tests/smem_buffer_checker.sv ====
`timescale 1ns/10ps

module smem_buffer_checker (
	input  logic clk,
	input  logic reset_n,
	input  logic output_request,
	input  logic output_valid,
	input  logic output_finish
);

	int   fail_count = 0;
	logic req_seen;

	// request raised at least once since the last reset
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			req_seen <= 1'b0;
		end else if (output_request) begin
			req_seen <= 1'b1;
		end
	end

	valid_not_finish: assert property (@(posedge clk) disable iff (!reset_n)
		!(output_valid && output_finish))
		else begin
			fail_count++;
			$error("output_valid and output_finish high together");
		end

	finish_held: assert property (@(posedge clk) $fell(output_finish) |-> $past(!reset_n))
		else begin
			fail_count++;
			$error("output_finish fell without a reset");
		end

	// first reset cycle still shows the old request
	request_in_reset: assert property (@(posedge clk)
		(!reset_n && $past(!reset_n)) |-> !output_request)
		else begin
			fail_count++;
			$error("output_request high within reset");
		end

	valid_after_request: assert property (@(posedge clk) disable iff (!reset_n)
		output_valid |-> req_seen)
		else begin
			fail_count++;
			$error("output_valid high before any output_request");
		end

endmodule

bind smem_buffer_top smem_buffer_checker protocol_check (
	.clk            (clk),
	.reset_n        (reset_n),
	.output_request (output_request),
	.output_valid   (output_valid),
	.output_finish  (output_finish)
);

// ==== tests/smem_buffer_tb.sv ====
`timescale 1ns/10ps

module smem_buffer_tb;
	import smem_pkg::*;

	localparam int PAT_WORDS = 64;
	localparam int NUM_BATCH = 2;

	logic                   clk;
	logic                   reset_n;
	logic [BATCH_W-1:0]     batch_size;
	logic                   slot_we;
	logic [READ_NUM_W-1:0]  slot_read_num;
	logic [SLOT_IDX_W-1:0]  slot_idx;
	lane_t                  slot_lane;
	rpt_t                   size_rpt;
	rpt_t                   ret_rpt;
	logic                   output_request;
	logic                   output_permit;
	out_beat_u              output_data;
	logic                   output_valid;
	logic                   output_finish;

	logic [7:0]             pat [0:PAT_WORDS-1];
	logic [LANE_W-1:0]      lane_model [MAX_READ][SLOTS_PER_READ];
	int                     size_tab [MAX_READ];
	int                     ret_tab [MAX_READ];
	logic [BEAT_W-1:0]      expect_q [$];
	logic                   hdr_q [$];
	logic                   permit_en = 1'b0;
	logic                   prev_valid = 1'b0;
	int                     error_count = 0;
	int                     beat_count = 0;
	int                     cycle_count = 0;
	int                     cycle_limit = 0;

	smem_buffer_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic compare_value(input logic [BEAT_W-1:0] got, input logic [BEAT_W-1:0] exp,
		input string what);
		if (got !== exp) begin
			error_count++;
			$display("ERROR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// expected words built from the field positions
	// ------------------------------------------------------------------------
	function automatic logic [LANE_W-1:0] field_mask();
		logic [LANE_W-1:0] m;
		m          = '0;
		m[230:224] = '1;
		m[198:192] = '1;
		m[160:128] = '1;
		m[96:64]   = '1;
		m[32:0]    = '1;
		return m;
	endfunction

	function automatic logic [LANE_W-1:0] random_lane();
		logic [LANE_W-1:0] l;
		for (int i = 0; i < LANE_W / 32; i++) begin
			l[i*32 +: 32] = $urandom;
		end
		return l & field_mask();
	endfunction

	function automatic logic [BEAT_W-1:0] header_word(input int rn, input int size, input int ret);
		logic [BEAT_W-1:0] w;
		w           = '0;
		w[9:0]      = 10'(rn);
		w[70:64]    = 7'(size);
		w[159:128]  = 32'(ret);
		return w;
	endfunction

	task automatic build_expected(input int bs);
		expect_q.delete();
		hdr_q.delete();
		for (int r = 0; r < bs; r++) begin
			expect_q.push_back(header_word(r, size_tab[r], ret_tab[r]));
			hdr_q.push_back(1'b1);
			for (int s = 0; s + 1 < size_tab[r]; s += 2) begin
				expect_q.push_back({lane_model[r][s+1], lane_model[r][s]});
				hdr_q.push_back(1'b0);
			end
			// odd last slot goes alone with the high half zero
			if (size_tab[r] % 2 == 1) begin
				expect_q.push_back({{LANE_W{1'b0}}, lane_model[r][size_tab[r]-1]});
				hdr_q.push_back(1'b0);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	task automatic apply_reset(input int bs);
		@(posedge clk);
		reset_n    <= 1'b0;
		batch_size <= BATCH_W'(bs);
		permit_en  <= 1'b0;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		compare_value(output_request, 1'b0, "output_request after reset");
		compare_value(output_valid, 1'b0, "output_valid after reset");
		compare_value(output_finish, 1'b0, "output_finish after reset");
	endtask

	task automatic load_slots(input int bs);
		logic [LANE_W-1:0] lane;
		for (int r = 0; r < bs; r++) begin
			for (int s = 0; s < size_tab[r]; s++) begin
				lane             = random_lane();
				lane_model[r][s] = lane;
				@(posedge clk);
				slot_we       <= 1'b1;
				slot_read_num <= READ_NUM_W'(r);
				slot_idx      <= SLOT_IDX_W'(s);
				slot_lane     <= lane;
			end
		end
		@(posedge clk);
		slot_we <= 1'b0;
	endtask

	task automatic send_reports(input int bs);
		for (int r = 0; r < bs; r++) begin
			// last report held back while no request may rise
			if (r == bs - 1) begin
				@(posedge clk);
				size_rpt <= '0;
				ret_rpt  <= '0;
				repeat (3) @(posedge clk);
				@(negedge clk);
				compare_value(output_request, 1'b0, "output_request before last report");
			end
			@(posedge clk);
			size_rpt <= '{valid: 1'b1, read_num: READ_NUM_W'(r), value: RET_W'(size_tab[r])};
			ret_rpt  <= '{valid: 1'b1, read_num: READ_NUM_W'(r), value: RET_W'(ret_tab[r])};
		end
		@(posedge clk);
		size_rpt <= '0;
		ret_rpt  <= '0;
	endtask

	task automatic run_batch(input int bs);
		apply_reset(bs);
		load_slots(bs);
		send_reports(bs);
		do @(negedge clk); while (!output_request);
		build_expected(bs);
		@(posedge clk);
		permit_en <= 1'b1;
		do @(negedge clk); while (!output_finish);
		compare_value(expect_q.size(), 0, "beats left at output_finish");
		repeat (4) begin
			@(negedge clk);
			compare_value(output_finish, 1'b1, "output_finish held");
		end
		@(posedge clk);
		permit_en <= 1'b0;
	endtask

	// permit drops on about one cycle in four
	always @(posedge clk) begin
		output_permit <= permit_en && ($urandom_range(0, 3) != 0);
	end

	always @(negedge clk) begin
		if (reset_n && output_valid) begin
			beat_count++;
			if (expect_q.size() == 0) begin
				error_count++;
				$display("ERROR %0t: beat arrived with no beat expected", $time);
			end else begin
				compare_value(prev_valid & hdr_q.pop_front(), 1'b0, "idle cycle before header");
				compare_value(output_data, expect_q.pop_front(), "beat data");
			end
		end
		prev_valid = output_valid;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, output stream never completed", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		int          idx;
		int          bs;
		int          total;
		reset_n       = 1'b0;
		batch_size    = '0;
		slot_we       = 1'b0;
		slot_read_num = '0;
		slot_idx      = '0;
		slot_lane     = '0;
		size_rpt      = '0;
		ret_rpt       = '0;
		output_permit = 1'b0;
		void'($urandom(32'h3f5f40e7));
		$readmemh("tests/smem_patterns.txt", pat);
		if (pat[0] === 8'hxx) begin
			$display("pattern file tests/smem_patterns.txt could not be read");
			$display("Done: errors found");
			$finish;
		end else begin
			// limit from the output length of both batches
			idx   = 0;
			total = 0;
			for (int b = 0; b < NUM_BATCH; b++) begin
				bs = pat[idx];
				idx++;
				for (int r = 0; r < bs; r++) begin
					total += pat[idx] + pat[idx] / 2 + 4;
					idx += 2;
				end
			end
			cycle_limit = 2 * total + 200;
			idx         = 0;
			for (int b = 0; b < NUM_BATCH; b++) begin
				bs = pat[idx];
				idx++;
				for (int r = 0; r < bs; r++) begin
					size_tab[r] = pat[idx];
					ret_tab[r]  = pat[idx+1];
					idx += 2;
				end
				run_batch(bs);
			end
			error_count += dut.protocol_check.fail_count;
			$display("checked %0d beats in %0d cycles, %0d errors", beat_count, cycle_count,
				error_count);
			if (error_count == 0) begin
				$display("Done: no errors");
			end else begin
				$display("Done: errors found");
			end
			$finish;
		end
	end

endmodule

// ==== tests/smem_patterns.txt ====
// batch_size on a line of its own, then one line per read: mem_size ret (hex)
// the second batch follows the first
06
03 1a
00 05
14 7f
07 33
02 41
01 2c
09
05 6e
10 01
00 3c
13 55
01 7a
08 09
0f 44
02 18
06 63

// ==== list.f ====
rtl/smem_pkg.sv
rtl/batch_tracker.sv
rtl/output_sequencer.sv
rtl/slot_store.sv
rtl/read_info_table.sv
rtl/output_packer.sv
rtl/smem_buffer_top.sv
tests/smem_buffer_checker.sv
tests/smem_buffer_tb.sv
